//--- all.f
+incdir+src
src/dct_pkg.sv
src/dct_sequencer.sv
src/dct_coeff_multiplier.sv
src/dct_scratchpad.sv
src/dct_datapath.sv
src/loeffler_dct_8.sv
bench/dct_sample_mem.sv
bench/dct_tb.sv

//--- bench/dct_sample_mem.sv
/*
 * Behavioral sample memory for the DCT testbench
 * eight samples loaded as one block, one-cycle synchronous read
 */

`default_nettype none

module dct_sample_mem import dct_pkg::*; (
    input  wire logic          clock,
    input  wire logic          load,
    input  wire sample_t [7:0] load_data,
    input  wire bin_t          addr,
    output sample_t            data
);

    timeunit 1ns;
    timeprecision 100ps;

    sample_t [7:0] buffer;

    initial begin
        buffer = '0;
        data   = '0;
    end

    always @(posedge clock) begin
        if (load) begin
            buffer <= load_data;  // whole frame swapped at once
        end
        data <= buffer[addr];     // answers the address of the previous cycle
    end

endmodule

`default_nettype wire

//--- bench/dct_tb.sv
/*
 * Testbench for the 8-point DCT engine
 * clock, reset, LFSR stimulus per frame, result collection,
 * schedule and value assertions, watchdog and summary
 */

`default_nettype none

`include "dct_defines.svh"

module dct_tb import dct_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD      = 8;
    localparam int RESET_CYCLES      = 10;
    localparam int FRAME_STEPS       = `DCT_UCODE_LEN + 1;
    localparam int NUM_FRAMES        = 8;
    localparam int FIRST_RESULT_STEP = 36;
    localparam int FRAME_DONE_STEP   = 56;
    // two spare frames on top of the whole run
    localparam int WATCHDOG_NS = (NUM_FRAMES + 2) * FRAME_STEPS * CLOCK_PERIOD
                                 + RESET_CYCLES * CLOCK_PERIOD;

    logic          clock;
    logic          nreset;
    logic          load;
    sample_t [7:0] load_data;
    sample_t       fetch_data;
    bin_t          fetch_addr;
    result_t       result;
    logic          frame_done;

    int         step_model;   // expected microprogram step
    logic       due;
    bin_t       due_index;
    word_t      got [8];
    int         hits [8];
    int         errors;
    logic [7:0] lfsr_state;

    sample_t [7:0] test_samples [NUM_FRAMES];
    word_t         test_expect [NUM_FRAMES][8];
    logic [7:0]    test_care [NUM_FRAMES];     // indices whose value is checked
    string         test_name [NUM_FRAMES];

    loeffler_dct_8 uut (
        .clock      (clock),
        .nreset     (nreset),
        .fetch_data (fetch_data),
        .fetch_addr (fetch_addr),
        .result     (result),
        .frame_done (frame_done)
    );

    dct_sample_mem sample_mem (
        .clock     (clock),
        .load      (load),
        .load_data (load_data),
        .addr      (fetch_addr),
        .data      (fetch_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            step_model <= 0;
        end else if (step_model == FRAME_STEPS - 1) begin
            step_model <= 0;
        end else begin
            step_model <= step_model + 1;
        end
    end

    // result write schedule of one frame
    always_comb begin
        due       = 1'b1;
        due_index = 3'd0;
        case (step_model)
            36: due_index = 3'd0;
            38: due_index = 3'd4;
            40: due_index = 3'd2;
            42: due_index = 3'd6;
            51: due_index = 3'd7;
            52: due_index = 3'd1;
            55: due_index = 3'd3;
            56: due_index = 3'd5;
            default: due = 1'b0;
        endcase
    end

    // gather the frame by index, cleared after the frame has been checked
    always_ff @(posedge clock) begin
        if (nreset || step_model == FRAME_STEPS - 1) begin
            for (int i = 0; i < 8; i++) begin
                hits[i] <= 0;
            end
        end else if (result.valid) begin
            got[result.index]  <= result.data;
            hits[result.index] <= hits[result.index] + 1;
        end
    end

    a_write_schedule: assert property (
        @(posedge clock) disable iff (nreset) result.valid == due
    ) else flag_mismatch("result.valid", $sampled(result.valid), $sampled(due));

    a_write_index: assert property (
        @(posedge clock) disable iff (nreset) result.valid |-> result.index == due_index
    ) else flag_mismatch("result.index", $sampled(result.index), $sampled(due_index));

    a_frame_done: assert property (
        @(posedge clock) disable iff (nreset) frame_done == (step_model == FRAME_DONE_STEP)
    ) else flag_mismatch("frame_done", $sampled(frame_done),
                         $sampled(step_model == FRAME_DONE_STEP));

    a_frame_period: assert property (
        @(posedge clock) disable iff (nreset) frame_done |-> ##58 frame_done
    ) else note_failure("frame_done did not come back 58 cycles later");

    task automatic flag_mismatch(input string signal, input logic [15:0] actual,
                                 input logic [15:0] expected);
        errors++;
        $display("[FAIL] %s = 0x%0h, expected 0x%0h", signal, actual, expected);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("check failed: %s", what);
    endtask

    // one LFSR step per bit taken, taps of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        logic       bit_out;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 8'hB8 : 8'h00);
            value      = {value[6:0], bit_out};
        end
        return value;
    endfunction

    // signed product truncated back to 7Q8
    function automatic word_t scaled_product(input int value, input int coeff);
        logic signed [31:0] full;
        full = value * coeff;
        return full[23:8];
    endfunction

    function automatic void set_constant(input int idx, input string name, input int c);
        word_t dc;
        dc = scaled_product(4 * c, `DCT_C_SQRT2_OVER4);
        test_name[idx] = name;
        test_care[idx] = 8'hFF;
        for (int i = 0; i < 8; i++) begin
            test_samples[idx][i] = sample_t'(c);
            test_expect[idx][i]  = '0;
        end
        test_expect[idx][0] = word_t'(2 * dc);  // both dc halves go through the multiplier
    endfunction

    function automatic void set_symmetric(input int idx, input string name);
        sample_t s;
        test_name[idx] = name;
        test_care[idx] = 8'b1010_1010;
        for (int i = 0; i < 4; i++) begin
            s = sample_t'(random_bits(8));
            test_samples[idx][i]     = s;
            test_samples[idx][7 - i] = s;
        end
        for (int i = 0; i < 8; i++) begin
            test_expect[idx][i] = '0;
        end
    endfunction

    function automatic void set_antisymmetric(input int idx, input string name);
        logic [7:0] mag;
        logic [7:0] sgn;
        sample_t    s;
        test_name[idx] = name;
        test_care[idx] = 8'b0101_0101;
        for (int i = 0; i < 4; i++) begin
            mag = random_bits(7);   // -128 has no positive partner
            sgn = random_bits(1);
            s   = sgn[0] ? -sample_t'(mag) : sample_t'(mag);
            test_samples[idx][i]     = s;
            test_samples[idx][7 - i] = -s;
        end
        for (int i = 0; i < 8; i++) begin
            test_expect[idx][i] = '0;
        end
    endfunction

    task automatic build_tests();
        set_constant(0, "zero input", 0);
        set_constant(1, "constant 5", 5);
        set_constant(2, "constant -128", -128);
        set_constant(3, "constant 127", 127);
        set_symmetric(4, "symmetric random 1");
        set_symmetric(5, "symmetric random 2");
        set_antisymmetric(6, "antisymmetric random 1");
        set_antisymmetric(7, "antisymmetric random 2");
    endtask

    // called on a falling edge, the memory takes the block on the next rising edge
    task automatic load_buffer(input sample_t [7:0] samples);
        load      = 1'b1;
        load_data = samples;
        @(negedge clock);
        load      = 1'b0;
    endtask

    task automatic wait_frame_done();
        do begin
            @(negedge clock);
        end while (!frame_done);
    endtask

    task automatic check_frame(input int t);
        for (int i = 0; i < 8; i++) begin
            assert (hits[i] == 1)
                else note_failure($sformatf("index %0d written %0d times in frame %0d",
                                            i, hits[i], t));
            if (test_care[t][i]) begin
                assert (got[i] == test_expect[t][i])
                    else flag_mismatch($sformatf("result.data[%0d]", i),
                                       got[i], test_expect[t][i]);
            end
        end
    endtask

    function automatic int report_test(input string name, input int errors_before);
        int failed;
        failed = (errors != errors_before);
        $display("test %s: %s", name, failed ? "failed" : "passed");
        return failed;
    endfunction

    initial begin
        int first_step;
        int errors_before;
        int tests_failed;
        nreset       = 1'b1;
        load         = 1'b0;
        load_data    = '0;
        errors       = 0;
        tests_failed = 0;
        lfsr_state   = 8'd81;
        build_tests();

        @(negedge clock);
        load_buffer(test_samples[0]);
        repeat (RESET_CYCLES - 2) @(negedge clock);
        nreset = 1'b0;                     // the release cycle is step 0

        // the 37th cycle after release is step 36
        errors_before = errors;
        first_step    = 0;
        while (!result.valid) begin
            @(negedge clock);
            first_step++;
        end
        assert (first_step == FIRST_RESULT_STEP)
            else flag_mismatch("first result step", first_step, FIRST_RESULT_STEP);
        tests_failed += report_test("quiet after reset", errors_before);

        for (int t = 0; t < NUM_FRAMES; t++) begin
            errors_before = errors;
            wait_frame_done();
            if (t + 1 < NUM_FRAMES) begin
                load_buffer(test_samples[t + 1]);
            end else begin
                @(negedge clock);
            end
            check_frame(t);                // step 57, all eight writes are in
            tests_failed += report_test(test_name[t], errors_before);
        end

        $display("summary: %0d tests, %0d failed, %0d errors",
                 NUM_FRAMES + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all frames were checked");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dct_coeff_multiplier.sv
/*
 * Coefficient multiplier
 * 8-entry 7Q8 coefficient table and a two-stage signed multiply
 */

`default_nettype none

`include "dct_defines.svh"

module dct_coeff_multiplier import dct_pkg::*; (
    input  wire logic       clock,
    input  wire word_t      operand,
    input  wire coeff_sel_t coeff_sel,
    output word_t           product
);

    coeff_t            coeff;
    word_t             operand_q;
    coeff_t            coeff_q;
    logic signed [31:0] product_q;

    always_comb begin
        case (coeff_sel)
            3'd0: coeff = `DCT_C_1C3_COS;
            3'd1: coeff = `DCT_C_1C3_SIN;
            3'd2: coeff = `DCT_C_1C1_COS;
            3'd3: coeff = `DCT_C_1C1_SIN;
            3'd4: coeff = `DCT_C_R2C1_COS;
            3'd5: coeff = `DCT_C_R2C1_SIN;
            3'd6: coeff = `DCT_C_SQRT2;
            default: coeff = `DCT_C_SQRT2_OVER4;
        endcase
    end

    always_ff @(posedge clock) begin
        operand_q <= operand;   // stage 1
        coeff_q   <= coeff;
        product_q <= operand_q * $signed({7'b0, coeff_q});  // stage 2, coefficient is positive
    end

    // drop the extra 8 fraction bits, back to 7Q8
    assign product = product_q[23:8];

endmodule

`default_nettype wire

//--- src/dct_datapath.sv
/*
 * DCT datapath
 * operand bus select, operand latch, negating adder
 * and write-back to the scratchpad or the result port
 */

`default_nettype none

module dct_datapath import dct_pkg::*; (
    input  wire logic    clock,
    input  wire logic    nreset,
    input  wire ucode_t  ucode,
    input  wire sample_t fetch_data,
    input  wire word_t   spad_rd_data,
    input  wire word_t   product,
    output word_t        operand_bus,
    output logic         spad_wr_en,
    output word_t        spad_wr_data,
    output result_t      result
);

    logic  rd_spad_q;     // source of the read issued last step
    word_t op_latch;
    word_t op1;
    word_t op2;
    word_t sum;
    word_t wb_data;

    // both memories answer one step after the address goes out
    always_ff @(posedge clock) begin
        if (nreset) begin
            rd_spad_q <= 1'b0;
        end else begin
            rd_spad_q <= ucode.rd_spad;
        end
    end

    assign operand_bus = rd_spad_q ? spad_rd_data : {{8{fetch_data[7]}}, fetch_data};

    always_ff @(posedge clock) begin
        if (nreset) begin
            op_latch <= '0;
        end else if (ucode.latch_op1) begin
            op_latch <= ucode.op1_from_mul ? product : operand_bus;
        end
    end

    // adder sees the latch value from before this step's load
    assign op1 = ucode.neg_op1 ? -op_latch : op_latch;
    assign op2 = ucode.op2_from_mul ? product : operand_bus;
    assign sum = op1 + (ucode.neg_op2 ? -op2 : op2);

    assign wb_data = ucode.wr_from_mul ? product : sum;

    assign spad_wr_en   = ucode.wr_en && !ucode.wr_out;
    assign spad_wr_data = wb_data;

    // result port, data is don't-care when valid is low
    assign result.valid = ucode.wr_en && ucode.wr_out;
    assign result.index = ucode.wr_addr[2:0];
    assign result.data  = wb_data;

endmodule

`default_nettype wire

//--- src/dct_defines.svh
/*
 * Macros for the 8-point DCT engine
 * microprogram length, scratchpad depth and the 7Q8 rotation coefficients
 */

`ifndef DCT_DEFINES_SVH
`define DCT_DEFINES_SVH

// index of the last microprogram step, a frame runs steps 0..57
`define DCT_UCODE_LEN 57

// scratchpad words, only the lower 24 are addressed by the microcode
`define DCT_SPAD_DEPTH 32

// 7Q8 roundings of the Loeffler rotation constants, coefficient selects 0..7
`define DCT_C_1C3_COS     9'd213  // cos(3pi/16)
`define DCT_C_1C3_SIN     9'd142  // sin(3pi/16)
`define DCT_C_1C1_COS     9'd251  // cos(pi/16)
`define DCT_C_1C1_SIN     9'd50   // sin(pi/16)
`define DCT_C_R2C1_COS    9'd139  // sqrt2 * cos(6pi/16)
`define DCT_C_R2C1_SIN    9'd334  // sqrt2 * sin(6pi/16)
`define DCT_C_SQRT2       9'd362
`define DCT_C_SQRT2_OVER4 9'd91

`endif

//--- src/dct_pkg.sv
/*
 * Shared types of the DCT engine
 * vector typedefs, the packed microinstruction and the result word
 */

`default_nettype none

package dct_pkg;

    typedef logic signed [7:0]  sample_t;    // input sample, integer
    typedef logic signed [15:0] word_t;      // 7Q8 datapath word
    typedef logic        [8:0]  coeff_t;     // unsigned 7Q8 coefficient
    typedef logic        [2:0]  coeff_sel_t;
    typedef logic        [4:0]  spad_addr_t; // scratchpad or sample address
    typedef logic        [5:0]  step_t;
    typedef logic        [2:0]  bin_t;       // sample or coefficient index

    // bit layout matches the microcode table, wr_from_mul is bit 21
    typedef struct packed {
        logic       wr_from_mul;  // product bypasses the adder
        logic       wr_en;
        logic       wr_out;       // 1 writes the result port, 0 the scratchpad
        spad_addr_t wr_addr;
        coeff_sel_t coeff_sel;
        logic       op2_from_mul;
        logic       op1_from_mul;
        logic       neg_op2;
        logic       neg_op1;
        logic       latch_op1;
        logic       rd_spad;      // 1 reads the scratchpad, 0 the sample memory
        spad_addr_t rd_addr;
    } ucode_t;

    typedef struct packed {
        logic  valid;
        bin_t  index;
        word_t data;
    } result_t;

endpackage

`default_nettype wire

//--- src/dct_scratchpad.sv
/*
 * Scratchpad RAM
 * synchronous write, registered read, block RAM style
 */

`default_nettype none

`include "dct_defines.svh"

module dct_scratchpad import dct_pkg::*; (
    input  wire logic       clock,
    input  wire logic       wr_en,
    input  wire spad_addr_t wr_addr,
    input  wire word_t      wr_data,
    input  wire spad_addr_t rd_addr,
    output word_t           rd_data
);

    word_t mem [`DCT_SPAD_DEPTH];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // old data on a same-address collision
    end

endmodule

`default_nettype wire

//--- src/dct_sequencer.sv
/*
 * Microprogram sequencer of the DCT engine
 * step counter, 58-step microcode ROM and the frame-done pulse
 */

`default_nettype none

`include "dct_defines.svh"

module dct_sequencer import dct_pkg::*; (
    input  wire logic clock,
    input  wire logic nreset,
    output ucode_t    ucode,
    output logic      frame_done
);

    localparam step_t LAST_WRITE_STEP = 6'd56;  // result index 5 goes out here
    localparam int unsigned SPAD_WORDS_USED = 24;

    step_t step;

    always_ff @(posedge clock) begin
        if (nreset) begin
            step <= '0;
        end else if (step == step_t'(`DCT_UCODE_LEN)) begin
            step <= '0;
        end else begin
            step <= step + 6'd1;
        end
    end

    // host swaps its sample buffer on this
    assign frame_done = (step == LAST_WRITE_STEP);

    // fields: {wr_from_mul, wr_en, wr_out}, wr_addr, coeff_sel,
    //         {op2_mul, op1_mul, neg_op2, neg_op1, latch}, rd_spad, rd_addr
    // a read issued in step k shows up on the operand bus in step k+1
    always_comb begin
        case (step)
            // butterfly stage, sample pairs from the sample memory
            6'd0:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd0};
            6'd1:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd7};  // latch x0
            6'd2:  ucode = {3'b010, 5'd0,  3'd0, 5'b00000, 1'b0, 5'd1};  // sp0 = x0 + x7
            6'd3:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd6};
            6'd4:  ucode = {3'b010, 5'd1,  3'd0, 5'b00000, 1'b0, 5'd2};  // sp1 = x1 + x6
            6'd5:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd5};
            6'd6:  ucode = {3'b010, 5'd2,  3'd0, 5'b00000, 1'b0, 5'd3};  // sp2 = x2 + x5
            6'd7:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd4};
            6'd8:  ucode = {3'b010, 5'd3,  3'd0, 5'b00000, 1'b0, 5'd3};  // sp3 = x3 + x4
            6'd9:  ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd4};
            6'd10: ucode = {3'b010, 5'd4,  3'd0, 5'b00100, 1'b0, 5'd2};  // sp4 = x3 - x4
            6'd11: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd5};
            6'd12: ucode = {3'b010, 5'd5,  3'd0, 5'b00100, 1'b0, 5'd1};  // sp5 = x2 - x5
            6'd13: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd6};
            6'd14: ucode = {3'b010, 5'd6,  3'd0, 5'b00100, 1'b0, 5'd0};  // sp6 = x1 - x6
            6'd15: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b0, 5'd7};
            // last sample consumed here, the read already targets the scratchpad
            6'd16: ucode = {3'b010, 5'd7,  3'd0, 5'b00100, 1'b1, 5'd0};  // sp7 = x0 - x7
            // even part
            6'd17: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd3};
            6'd18: ucode = {3'b010, 5'd8,  3'd0, 5'b00000, 1'b1, 5'd1};  // sp8 = sp0 + sp3
            6'd19: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd2};
            6'd20: ucode = {3'b010, 5'd9,  3'd0, 5'b00000, 1'b1, 5'd1};  // sp9 = sp1 + sp2
            6'd21: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd2};
            6'd22: ucode = {3'b010, 5'd10, 3'd0, 5'b00100, 1'b1, 5'd0};  // sp10 = sp1 - sp2
            6'd23: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd3};
            6'd24: ucode = {3'b010, 5'd11, 3'd0, 5'b00100, 1'b1, 5'd4};  // sp11 = sp0 - sp3
            // odd rotations, products come back two steps after issue
            6'd25: ucode = {3'b000, 5'd0,  3'd0, 5'b00000, 1'b1, 5'd7};
            6'd26: ucode = {3'b000, 5'd0,  3'd1, 5'b00000, 1'b1, 5'd4};
            6'd27: ucode = {3'b000, 5'd0,  3'd1, 5'b01001, 1'b1, 5'd7};
            6'd28: ucode = {3'b010, 5'd12, 3'd0, 5'b10000, 1'b1, 5'd5};
            6'd29: ucode = {3'b000, 5'd0,  3'd2, 5'b01001, 1'b1, 5'd6};
            6'd30: ucode = {3'b010, 5'd15, 3'd3, 5'b10010, 1'b1, 5'd5};
            6'd31: ucode = {3'b000, 5'd0,  3'd3, 5'b01001, 1'b1, 5'd6};
            6'd32: ucode = {3'b010, 5'd13, 3'd2, 5'b10000, 1'b1, 5'd8};
            6'd33: ucode = {3'b000, 5'd0,  3'd7, 5'b01001, 1'b1, 5'd9};
            6'd34: ucode = {3'b010, 5'd14, 3'd7, 5'b10010, 1'b1, 5'd8};
            // even outputs
            6'd35: ucode = {3'b000, 5'd0,  3'd7, 5'b01001, 1'b1, 5'd9};
            6'd36: ucode = {3'b011, 5'd0,  3'd7, 5'b10000, 1'b1, 5'd10}; // out0
            6'd37: ucode = {3'b000, 5'd0,  3'd4, 5'b01001, 1'b1, 5'd11};
            6'd38: ucode = {3'b011, 5'd4,  3'd5, 5'b10100, 1'b1, 5'd10}; // out4
            6'd39: ucode = {3'b000, 5'd0,  3'd5, 5'b01001, 1'b1, 5'd11};
            6'd40: ucode = {3'b011, 5'd2,  3'd4, 5'b10000, 1'b1, 5'd0};  // out2
            6'd41: ucode = {3'b000, 5'd0,  3'd0, 5'b01001, 1'b1, 5'd12}; // sp10 * r2c1 sin
            6'd42: ucode = {3'b011, 5'd6,  3'd0, 5'b10011, 1'b1, 5'd14}; // out6, latch sp12
            // odd part, last butterflies
            6'd43: ucode = {3'b010, 5'd20, 3'd0, 5'b00000, 1'b1, 5'd13}; // sp20 = sp12 + sp14
            6'd44: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd15};
            6'd45: ucode = {3'b010, 5'd21, 3'd0, 5'b00010, 1'b1, 5'd12}; // sp21 = sp15 - sp13
            6'd46: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd14};
            6'd47: ucode = {3'b010, 5'd22, 3'd0, 5'b00100, 1'b1, 5'd13}; // sp22 = sp12 - sp14
            6'd48: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd15};
            6'd49: ucode = {3'b010, 5'd23, 3'd0, 5'b00000, 1'b1, 5'd20}; // sp23 = sp13 + sp15
            6'd50: ucode = {3'b000, 5'd0,  3'd0, 5'b00001, 1'b1, 5'd23};
            6'd51: ucode = {3'b011, 5'd7,  3'd0, 5'b00010, 1'b1, 5'd23}; // out7
            6'd52: ucode = {3'b011, 5'd1,  3'd0, 5'b00000, 1'b1, 5'd21}; // out1
            6'd53: ucode = {3'b000, 5'd0,  3'd6, 5'b00000, 1'b1, 5'd22};
            6'd54: ucode = {3'b000, 5'd0,  3'd6, 5'b00000, 1'b1, 5'd0};
            6'd55: ucode = {3'b111, 5'd3,  3'd0, 5'b00000, 1'b1, 5'd0};  // out3 = sp21 * sqrt2
            6'd56: ucode = {3'b111, 5'd5,  3'd0, 5'b00000, 1'b1, 5'd0};  // out5 = sp22 * sqrt2
            default: ucode = '0;                                          // step 57, idle
        endcase
    end

    a_step_in_range: assert property (
        @(posedge clock) disable iff (nreset)
        step <= step_t'(`DCT_UCODE_LEN)
    ) else $error("step 0x%0h beyond the microprogram", step);

    // the scratchpad is 32 deep but the program only owns the low 24 words
    a_spad_write_range: assert property (
        @(posedge clock) disable iff (nreset)
        (ucode.wr_en && !ucode.wr_out) |-> (ucode.wr_addr < SPAD_WORDS_USED)
    ) else $error("scratchpad write to 0x%0h in step %0d", ucode.wr_addr, step);

endmodule

`default_nettype wire

//--- src/loeffler_dct_8.sv
/*
 * 8-point Loeffler DCT engine, top level
 * sequencer, datapath, scratchpad and coefficient multiplier
 */

`default_nettype none

module loeffler_dct_8 import dct_pkg::*; (
    input  wire logic    clock,
    input  wire logic    nreset,
    input  wire sample_t fetch_data,
    output bin_t         fetch_addr,
    output result_t      result,
    output logic         frame_done
);

    ucode_t ucode;
    word_t  operand_bus;
    word_t  product;
    word_t  spad_rd_data;
    word_t  spad_wr_data;
    logic   spad_wr_en;

    dct_sequencer u_sequencer (
        .clock      (clock),
        .nreset     (nreset),
        .ucode      (ucode),
        .frame_done (frame_done)
    );

    dct_datapath u_datapath (
        .clock        (clock),
        .nreset       (nreset),
        .ucode        (ucode),
        .fetch_data   (fetch_data),
        .spad_rd_data (spad_rd_data),
        .product      (product),
        .operand_bus  (operand_bus),
        .spad_wr_en   (spad_wr_en),
        .spad_wr_data (spad_wr_data),
        .result       (result)
    );

    dct_scratchpad u_scratchpad (
        .clock   (clock),
        .wr_en   (spad_wr_en),
        .wr_addr (ucode.wr_addr),
        .wr_data (spad_wr_data),
        .rd_addr (ucode.rd_addr),
        .rd_data (spad_rd_data)
    );

    dct_coeff_multiplier u_multiplier (
        .clock     (clock),
        .operand   (operand_bus),
        .coeff_sel (ucode.coeff_sel),
        .product   (product)
    );

    assign fetch_addr = ucode.rd_addr[2:0];  // sample memory holds 8 entries

endmodule

`default_nettype wire
